//--- Bender.yml
package:
  name: core_mem_region

sources:
  - verilog/core_region_pkg.sv
  - verilog/sp_ram.sv
  - verilog/lsu_demux.sv
  - verilog/ext_credit_port.sv
  - verilog/data_ram_mux.sv
  - verilog/core_mem_region.sv
  - target: test
    files:
      - tests/tb_core_mem_region.sv

//--- sources.f
verilog/core_region_pkg.sv
verilog/sp_ram.sv
verilog/lsu_demux.sv
verilog/ext_credit_port.sv
verilog/data_ram_mux.sv
verilog/core_mem_region.sv
tests/tb_core_mem_region.sv

//--- tests/tb_core_mem_region.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_mem_region
  import core_region_pkg::*;
();

  localparam int          TIMEOUT    = 200;
  localparam logic [31:0] LOCAL_BASE = 32'h0010_0000;
  localparam logic [31:0] EXT_BASE   = 32'h4000_0000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  lsu_req_valid;
  lsu_req_t              lsu_req;
  logic                  lsu_gnt;
  logic                  lsu_rvalid;
  logic [LSU_DATA_W-1:0] lsu_rdata;
  logic                  bus_req_valid;
  bus_req_t              bus_req;
  logic                  bus_rvalid;
  logic [RAM_DATA_W-1:0] bus_rdata;
  logic                  ext_req_valid;
  lsu_req_t              ext_req;
  logic                  ext_credit    = 1'b0;
  logic                  ext_rsp_valid = 1'b0;
  logic [LSU_DATA_W-1:0] ext_rdata     = '0;

  // reference RAM and expected core responses, in request order
  logic [RAM_DATA_W-1:0] ref_mem [RAM_WORDS];
  logic [LSU_DATA_W-1:0] exp_data [64];
  logic                  exp_chk [64];
  int                    head = 0;
  int                    tail = 0;
  logic                  exp_pending;
  logic [LSU_DATA_W-1:0] exp_head_data;
  logic                  exp_head_chk;
  logic [RAM_DATA_W-1:0] bus_exp_data;
  logic                  bus_exp_chk = 1'b0;
  logic                  req_local;

  // external bus model state
  logic [LSU_ADDR_W-1:0] mdl_addr [64];
  int                    mdl_due [64];
  int                    mhead        = 0;
  int                    mtail        = 0;
  int                    last_due     = 0;
  int                    credits_owed = 0;
  int                    ext_inflight = 0;
  int                    cycle        = 0;
  logic                  hold_credits = 1'b0;

  string       test_name = "reset";
  int          err_cnt   = 0;
  int          err_start = 0;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  int unsigned rnd;

  always #50 clk = ~clk;

  core_mem_region dut0 (
    .clk             ( clk           ),
    .rst_n           ( rst_n         ),
    .lsu_req_valid_i ( lsu_req_valid ),
    .lsu_req_i       ( lsu_req       ),
    .lsu_gnt_o       ( lsu_gnt       ),
    .lsu_rvalid_o    ( lsu_rvalid    ),
    .lsu_rdata_o     ( lsu_rdata     ),
    .bus_req_valid_i ( bus_req_valid ),
    .bus_req_i       ( bus_req       ),
    .bus_rvalid_o    ( bus_rvalid    ),
    .bus_rdata_o     ( bus_rdata     ),
    .ext_req_valid_o ( ext_req_valid ),
    .ext_req_o       ( ext_req       ),
    .ext_credit_i    ( ext_credit    ),
    .ext_rsp_valid_i ( ext_rsp_valid ),
    .ext_rdata_i     ( ext_rdata     )
  );

  assign req_local     = (lsu_req.addr[REGION_MSB:REGION_LSB] == LOCAL_REGION);
  assign exp_pending   = (head != tail);
  assign exp_head_data = exp_data[head % 64];
  assign exp_head_chk  = exp_chk[head % 64];

  function automatic void write_ref(input logic [RAM_WORD_ADDR_W-1:0] w,
                                    input logic [RAM_BE_W-1:0] be,
                                    input logic [RAM_DATA_W-1:0] d);
    for (int i = 0; i < RAM_BE_W; i++)
    begin
      if (be[i])
        ref_mem[w][i*8 +: 8] = d[i*8 +: 8];
    end
  endfunction

  // reference updates and expected values, taken at grant time
  always @(posedge clk)
  begin
    logic [RAM_WORD_ADDR_W-1:0] w;
    int                         due;
    if (rst_n)
    begin
      if (bus_req_valid)
      begin
        w            = bus_req.addr[DATA_ADDR_W-1:3];
        bus_exp_chk  = !bus_req.we;
        bus_exp_data = ref_mem[w];
        if (bus_req.we)
          write_ref(w, bus_req.be, bus_req.wdata);
      end
      if (lsu_req_valid && lsu_gnt)
      begin
        w = lsu_req.addr[DATA_ADDR_W-1:3];
        if (!req_local)
          exp_data[tail % 64] = ~lsu_req.addr;
        else if (lsu_req.addr[2])
          exp_data[tail % 64] = ref_mem[w][63:32];
        else
          exp_data[tail % 64] = ref_mem[w][31:0];
        exp_chk[tail % 64] = !lsu_req.we;
        tail++;
        if (req_local && lsu_req.we)
          write_ref(w, lsu_req.addr[2] ? {lsu_req.be, 4'h0} : {4'h0, lsu_req.be},
                    {2{lsu_req.wdata}});
      end
      if (lsu_rvalid && exp_pending)
        head++;
      // bus model takes the request, answers in order 1 to 6 cycles later
      if (ext_req_valid)
      begin
        due = cycle + 1 + int'($urandom % 6);
        if (due <= last_due)
          due = last_due + 1;
        last_due             = due;
        mdl_addr[mtail % 64] = ext_req.addr;
        mdl_due[mtail % 64]  = due;
        mtail++;
        credits_owed++;
        ext_inflight++;
      end
      if (ext_credit)
        ext_inflight--;
    end
  end

  always @(negedge clk)
  begin
    cycle++;
    ext_credit    = 1'b0;
    ext_rsp_valid = 1'b0;
    if (!hold_credits && credits_owed > 0)
    begin
      ext_credit = 1'b1;
      credits_owed--;
    end
    if (mhead != mtail && mdl_due[mhead % 64] <= cycle)
    begin
      ext_rsp_valid = 1'b1;
      ext_rdata     = ~mdl_addr[mhead % 64];
      mhead++;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) lsu_rvalid |-> exp_pending)
  else
  begin
    $display("%s: load/store response with no request outstanding", test_name);
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_rvalid && exp_pending && exp_head_chk) |-> (lsu_rdata === exp_head_data))
  else
  begin
    $display("Error: %s lsu_rdata expected %h actual %h", test_name,
             $sampled(exp_head_data), $sampled(lsu_rdata));
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_req_valid && lsu_gnt && req_local) |=> lsu_rvalid)
  else
  begin
    $display("%s: local response did not follow its grant by one cycle", test_name);
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n) bus_req_valid |=> bus_rvalid)
  else
  begin
    $display("%s: bus response missing one cycle after the request", test_name);
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (bus_rvalid && bus_exp_chk) |-> (bus_rdata === bus_exp_data))
  else
  begin
    $display("Error: %s bus_rdata expected %h actual %h", test_name,
             $sampled(bus_exp_data), $sampled(bus_rdata));
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_valid && lsu_req_valid && req_local) |-> !lsu_gnt)
  else
  begin
    $display("%s: core granted the RAM while the bus was using it", test_name);
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_valid |-> (lsu_req_valid && (ext_req === lsu_req)))
  else
  begin
    $display("Error: %s ext_req expected %h actual %h", test_name,
             $sampled(lsu_req), $sampled(ext_req));
    err_cnt++;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    ext_req_valid |-> (ext_inflight < EXT_CREDITS))
  else
  begin
    $display("%s: external request sent without a credit", test_name);
    err_cnt++;
  end

  task automatic core_wait_gnt();
    int t;
    for (t = 0; t < TIMEOUT; t++)
    begin
      @(posedge clk);
      if (lsu_gnt)
        break;
    end
    if (t == TIMEOUT)
    begin
      $display("%s: core request to %h was never granted", test_name, lsu_req.addr);
      err_cnt++;
    end
  endtask

  task automatic core_access(input logic [31:0] a, input logic we,
                             input logic [3:0] be, input logic [31:0] d);
    @(negedge clk);
    lsu_req_valid = 1'b1;
    lsu_req       = '{addr: a, we: we, be: be, wdata: d};
    core_wait_gnt();
  endtask

  task automatic core_idle();
    @(negedge clk);
    lsu_req_valid = 1'b0;
  endtask

  task automatic bus_access(input logic [DATA_ADDR_W-1:0] a, input logic we,
                            input logic [7:0] be, input logic [63:0] d);
    @(negedge clk);
    bus_req_valid = 1'b1;
    bus_req       = '{addr: a, we: we, be: be, wdata: d};
    @(negedge clk);
    bus_req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    for (t = 0; t < TIMEOUT; t++)
    begin
      @(negedge clk);
      if (head == tail && mhead == mtail && !bus_rvalid)
        break;
    end
    if (t == TIMEOUT)
    begin
      $display("%s: responses still outstanding after the timeout", test_name);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_start)
    begin
      pass_cnt++;
      $display("test %s: ok", test_name);
    end
    else
    begin
      fail_cnt++;
      $display("test %s: %0d error(s)", test_name, err_cnt - err_start);
    end
  endtask

  initial
  begin
    rnd           = $urandom(7589);
    rst_n         = 1'b0;
    lsu_req_valid = 1'b0;
    lsu_req       = '0;
    bus_req_valid = 1'b0;
    bus_req       = '0;

    start_test("reset");
    repeat (10) @(posedge clk);
    assert (!lsu_gnt && !lsu_rvalid && !ext_req_valid && !bus_rvalid)
    else
    begin
      $display("%s: outputs not idle during reset", test_name);
      err_cnt++;
    end
    @(negedge clk);
    rst_n = 1'b1;
    end_test();

    // full words first, then mixed byte enables on top
    start_test("local_rw");
    for (int i = 0; i < 4; i++)
      core_access(LOCAL_BASE + 32'h200 + i*4, 1'b1, 4'hF, $urandom);
    for (int i = 0; i < 4; i++)
      core_access(LOCAL_BASE + 32'h200 + i*4, 1'b1, 4'($urandom), $urandom);
    for (int i = 0; i < 4; i++)
      core_access(LOCAL_BASE + 32'h200 + i*4, 1'b0, 4'h0, 32'h0);
    core_idle();
    wait_drain();
    end_test();

    start_test("width");
    bus_access(15'h0100, 1'b1, 8'hFF, {$urandom, $urandom});
    core_access(LOCAL_BASE + 32'h100, 1'b0, 4'h0, 32'h0);
    core_access(LOCAL_BASE + 32'h104, 1'b0, 4'h0, 32'h0);
    core_access(LOCAL_BASE + 32'h104, 1'b1, 4'b0110, $urandom);
    core_idle();
    bus_access(15'h0100, 1'b0, 8'h00, 64'h0);
    wait_drain();
    end_test();

    start_test("bus_priority");
    for (int i = 0; i < 4; i++)
      core_access(LOCAL_BASE + 32'h300 + i*4, 1'b1, 4'hF, $urandom);
    @(negedge clk);
    bus_req_valid = 1'b1;
    bus_req       = '{addr: 15'h0300, we: 1'b0, be: 8'h00, wdata: 64'h0};
    lsu_req       = '{addr: LOCAL_BASE + 32'h308, we: 1'b0, be: 4'h0, wdata: 32'h0};
    fork
      core_wait_gnt();
      begin
        @(negedge clk);
        bus_req_valid = 1'b0;
      end
    join
    core_idle();
    wait_drain();
    end_test();

    start_test("ext_route");
    core_access(EXT_BASE + 32'h40, 1'b1, 4'hA, $urandom);
    core_access(EXT_BASE + 32'h44, 1'b0, 4'h0, 32'h0);
    core_access(32'h8000_0048, 1'b0, 4'h0, 32'h0);
    core_idle();
    wait_drain();
    end_test();

    // more requests than credits while the model keeps them
    start_test("backpressure");
    hold_credits = 1'b1;
    fork
      for (int i = 0; i < EXT_CREDITS + 2; i++)
        core_access(EXT_BASE + 32'h80 + i*4, 1'b0, 4'h0, 32'h0);
      begin
        repeat (12) @(posedge clk);
        hold_credits = 1'b0;
      end
    join
    core_idle();
    wait_drain();
    end_test();

    start_test("switch");
    for (int i = 0; i < 3; i++)
      core_access(EXT_BASE + 32'h100 + i*4, 1'b0, 4'h0, 32'h0);
    for (int i = 0; i < 3; i++)
      core_access(LOCAL_BASE + 32'h200 + i*4, 1'b0, 4'h0, 32'h0);
    core_access(EXT_BASE + 32'h200, 1'b0, 4'h0, 32'h0);
    core_idle();
    wait_drain();
    end_test();

    $display("tests passed %0d, tests failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/core_mem_region.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_region import core_region_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  // load/store unit
  input  wire logic                  lsu_req_valid_i,
  input  wire lsu_req_t              lsu_req_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output logic      [LSU_DATA_W-1:0] lsu_rdata_o,
  // bus slave into the data RAM
  input  wire logic                  bus_req_valid_i,
  input  wire bus_req_t              bus_req_i,
  output logic                       bus_rvalid_o,
  output logic      [RAM_DATA_W-1:0] bus_rdata_o,
  // external request port
  output logic                       ext_req_valid_o,
  output lsu_req_t                   ext_req_o,
  input  wire logic                  ext_credit_i,
  input  wire logic                  ext_rsp_valid_i,
  input  wire logic [LSU_DATA_W-1:0] ext_rdata_i
);

  logic                       local_req_valid;
  logic                       local_gnt;
  logic                       local_rvalid;
  logic [LSU_DATA_W-1:0]      local_rdata;
  logic                       ext_req_valid;
  logic                       ext_gnt;
  logic                       ext_rvalid;
  logic [LSU_DATA_W-1:0]      ext_rdata;
  logic                       ram_en;
  logic                       ram_we;
  logic [RAM_WORD_ADDR_W-1:0] ram_addr;
  logic [RAM_BE_W-1:0]        ram_be;
  logic [RAM_DATA_W-1:0]      ram_wdata;
  logic [RAM_DATA_W-1:0]      ram_rdata;

  lsu_demux lsu_demux_i (
    .clk               ( clk             ),
    .rst_n             ( rst_n           ),
    .lsu_req_valid_i   ( lsu_req_valid_i ),
    .lsu_req_i         ( lsu_req_i       ),
    .lsu_gnt_o         ( lsu_gnt_o       ),
    .lsu_rvalid_o      ( lsu_rvalid_o    ),
    .lsu_rdata_o       ( lsu_rdata_o     ),
    .local_req_valid_o ( local_req_valid ),
    .local_gnt_i       ( local_gnt       ),
    .local_rvalid_i    ( local_rvalid    ),
    .local_rdata_i     ( local_rdata     ),
    .ext_req_valid_o   ( ext_req_valid   ),
    .ext_gnt_i         ( ext_gnt         ),
    .ext_rvalid_i      ( ext_rvalid      ),
    .ext_rdata_i       ( ext_rdata       )
  );

  ext_credit_port ext_port_i (
    .clk             ( clk             ),
    .rst_n           ( rst_n           ),
    .req_valid_i     ( ext_req_valid   ),
    .req_i           ( lsu_req_i       ),
    .gnt_o           ( ext_gnt         ),
    .rvalid_o        ( ext_rvalid      ),
    .rdata_o         ( ext_rdata       ),
    .ext_req_valid_o ( ext_req_valid_o ),
    .ext_req_o       ( ext_req_o       ),
    .ext_credit_i    ( ext_credit_i    ),
    .ext_rsp_valid_i ( ext_rsp_valid_i ),
    .ext_rdata_i     ( ext_rdata_i     )
  );

  data_ram_mux data_ram_mux_i (
    .clk              ( clk             ),
    .rst_n            ( rst_n           ),
    .bus_req_valid_i  ( bus_req_valid_i ),
    .bus_req_i        ( bus_req_i       ),
    .bus_rvalid_o     ( bus_rvalid_o    ),
    .bus_rdata_o      ( bus_rdata_o     ),
    .core_req_valid_i ( local_req_valid ),
    .core_req_i       ( lsu_req_i       ),
    .core_gnt_o       ( local_gnt       ),
    .core_rvalid_o    ( local_rvalid    ),
    .core_rdata_o     ( local_rdata     ),
    .ram_en_o         ( ram_en          ),
    .ram_we_o         ( ram_we          ),
    .ram_addr_o       ( ram_addr        ),
    .ram_be_o         ( ram_be          ),
    .ram_wdata_o      ( ram_wdata       ),
    .ram_rdata_i      ( ram_rdata       )
  );

  sp_ram data_mem_i (
    .clk     ( clk       ),
    .en_i    ( ram_en    ),
    .we_i    ( ram_we    ),
    .addr_i  ( ram_addr  ),
    .be_i    ( ram_be    ),
    .wdata_i ( ram_wdata ),
    .rdata_o ( ram_rdata )
  );

endmodule

`default_nettype wire

//--- verilog/core_region_pkg.sv
`default_nettype none

package core_region_pkg;

  // load/store port widths
  localparam int LSU_ADDR_W = 32;
  localparam int LSU_DATA_W = 32;
  localparam int LSU_BE_W   = LSU_DATA_W / 8;

  // data RAM geometry
  localparam int RAM_DATA_W      = 64;
  localparam int RAM_BE_W        = RAM_DATA_W / 8;
  localparam int DATA_RAM_BYTES  = 32768;
  localparam int DATA_ADDR_W     = $clog2(DATA_RAM_BYTES);
  localparam int RAM_WORDS       = DATA_RAM_BYTES / RAM_BE_W;
  localparam int RAM_WORD_ADDR_W = $clog2(RAM_WORDS);

  // address map, upper bits pick the region
  localparam int                           REGION_MSB   = 31;
  localparam int                           REGION_LSB   = 20;
  localparam logic [REGION_MSB:REGION_LSB] LOCAL_REGION = 12'h001;

  // external port credits
  localparam int EXT_CREDITS = 4;
  localparam int CREDIT_W    = $clog2(EXT_CREDITS + 1);

  // outstanding response counter in the demux
  // credits return ahead of responses, so this can exceed EXT_CREDITS
  localparam int OUTST_W = 4;

  // one load/store request as issued by the core
  typedef struct packed {
    logic [LSU_ADDR_W-1:0] addr;
    logic                  we;
    logic [LSU_BE_W-1:0]   be;
    logic [LSU_DATA_W-1:0] wdata;
  } lsu_req_t;

  // bus side access, full RAM word
  typedef struct packed {
    logic [DATA_ADDR_W-1:0] addr;
    logic                   we;
    logic [RAM_BE_W-1:0]    be;
    logic [RAM_DATA_W-1:0]  wdata;
  } bus_req_t;

  // who owes the outstanding load/store responses
  typedef enum logic [0:0] {
    RESP_LOCAL = 1'b0,
    RESP_EXT   = 1'b1
  } resp_src_e;

endpackage

`default_nettype wire

//--- verilog/data_ram_mux.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram_mux import core_region_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  // bus slave side always wins
  input  wire logic                       bus_req_valid_i,
  input  wire bus_req_t                   bus_req_i,
  output logic                            bus_rvalid_o,
  output logic           [RAM_DATA_W-1:0] bus_rdata_o,
  // 32-bit core side
  input  wire logic                       core_req_valid_i,
  input  wire lsu_req_t                   core_req_i,
  output logic                            core_gnt_o,
  output logic                            core_rvalid_o,
  output logic           [LSU_DATA_W-1:0] core_rdata_o,
  // RAM side
  output logic                            ram_en_o,
  output logic                            ram_we_o,
  output logic      [RAM_WORD_ADDR_W-1:0] ram_addr_o,
  output logic             [RAM_BE_W-1:0] ram_be_o,
  output logic           [RAM_DATA_W-1:0] ram_wdata_o,
  input  wire logic      [RAM_DATA_W-1:0] ram_rdata_i
);

  logic                       core_hi;
  logic [RAM_WORD_ADDR_W-1:0] core_word;
  logic [RAM_BE_W-1:0]        core_be;
  logic                       bus_rvalid_q;
  logic                       core_rvalid_q;
  logic                       core_hi_q;

  // word index and upper/lower half of the core access
  assign core_word = core_req_i.addr[DATA_ADDR_W-1:DATA_ADDR_W-RAM_WORD_ADDR_W];
  assign core_hi   = core_req_i.addr[2];
  assign core_be   = core_hi ? {core_req_i.be, {LSU_BE_W{1'b0}}}
                             : {{LSU_BE_W{1'b0}}, core_req_i.be};

  assign core_gnt_o = core_req_valid_i & ~bus_req_valid_i;
  assign ram_en_o   = bus_req_valid_i | core_req_valid_i;

  always_comb
  begin
    if (bus_req_valid_i)
    begin
      ram_we_o    = bus_req_i.we;
      ram_addr_o  = bus_req_i.addr[DATA_ADDR_W-1:DATA_ADDR_W-RAM_WORD_ADDR_W];
      ram_be_o    = bus_req_i.be;
      ram_wdata_o = bus_req_i.wdata;
    end
    else
    begin
      ram_we_o    = core_req_i.we;
      ram_addr_o  = core_word;
      ram_be_o    = core_be;
      // same data in both halves and the byte enables pick the half written
      ram_wdata_o = {2{core_req_i.wdata}};
    end
  end

  // owner and half of the access kept for the returned word
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      bus_rvalid_q  <= 1'b0;
      core_rvalid_q <= 1'b0;
      core_hi_q     <= 1'b0;
    end
    else
    begin
      bus_rvalid_q  <= bus_req_valid_i;
      core_rvalid_q <= core_gnt_o;
      if (core_gnt_o)
        core_hi_q <= core_hi;
    end
  end

  assign bus_rvalid_o  = bus_rvalid_q;
  assign bus_rdata_o   = ram_rdata_i;
  assign core_rvalid_o = core_rvalid_q;
  assign core_rdata_o  = core_hi_q ? ram_rdata_i[RAM_DATA_W-1:LSU_DATA_W]
                                   : ram_rdata_i[LSU_DATA_W-1:0];

  // a core request held off by the bus stays unchanged until it gets the RAM
  assert property (@(posedge clk) disable iff (!rst_n)
    (core_req_valid_i && bus_req_valid_i) |=> (core_req_valid_i && $stable(core_req_i)));

endmodule

`default_nettype wire

//--- verilog/ext_credit_port.sv
`timescale 1ns/1ps
`default_nettype none

module ext_credit_port import core_region_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_valid_i,
  input  wire lsu_req_t              req_i,
  output logic                       gnt_o,
  output logic                       rvalid_o,
  output logic      [LSU_DATA_W-1:0] rdata_o,
  output logic                       ext_req_valid_o,
  output lsu_req_t                   ext_req_o,
  input  wire logic                  ext_credit_i,
  input  wire logic                  ext_rsp_valid_i,
  input  wire logic [LSU_DATA_W-1:0] ext_rdata_i
);

  logic [CREDIT_W-1:0] credit_q;
  logic [CREDIT_W-1:0] credit_d;
  logic                have_credit;

  assign have_credit = (credit_q != '0);

  // a request leaves only while a credit is held
  assign gnt_o           = req_valid_i & have_credit;
  assign ext_req_valid_o = gnt_o;
  assign ext_req_o       = req_i;

  // outside world answers in order
  assign rvalid_o = ext_rsp_valid_i;
  assign rdata_o  = ext_rdata_i;

  always_comb
  begin
    credit_d = credit_q;
    if (gnt_o && !ext_credit_i)
      credit_d = credit_q - 1'b1;
    else if (!gnt_o && ext_credit_i)
      credit_d = credit_q + 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      credit_q <= CREDIT_W'(EXT_CREDITS);
    else
      credit_q <= credit_d;
  end

  // counter stays in range
  assert property (@(posedge clk) disable iff (!rst_n)
    credit_q <= CREDIT_W'(EXT_CREDITS));

  // a credit must belong to a request that was sent
  assert property (@(posedge clk) disable iff (!rst_n)
    ext_credit_i |-> (credit_q < CREDIT_W'(EXT_CREDITS)));

endmodule

`default_nettype wire

//--- verilog/lsu_demux.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_demux import core_region_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  lsu_req_valid_i,
  input  wire lsu_req_t              lsu_req_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  output logic      [LSU_DATA_W-1:0] lsu_rdata_o,
  output logic                       local_req_valid_o,
  input  wire logic                  local_gnt_i,
  input  wire logic                  local_rvalid_i,
  input  wire logic [LSU_DATA_W-1:0] local_rdata_i,
  output logic                       ext_req_valid_o,
  input  wire logic                  ext_gnt_i,
  input  wire logic                  ext_rvalid_i,
  input  wire logic [LSU_DATA_W-1:0] ext_rdata_i
);

  logic               is_local;
  resp_src_e          req_src;
  resp_src_e          resp_src_q;
  logic [OUTST_W-1:0] outst_q;
  logic [OUTST_W-1:0] outst_d;
  logic               may_issue;

  assign is_local = (lsu_req_i.addr[REGION_MSB:REGION_LSB] == LOCAL_REGION);
  assign req_src  = is_local ? RESP_LOCAL : RESP_EXT;

  // hold off a target switch until the old target has drained
  assign may_issue = ((outst_q == '0) || (resp_src_q == req_src)) && (outst_q != '1);

  assign local_req_valid_o = lsu_req_valid_i & may_issue & is_local;
  assign ext_req_valid_o   = lsu_req_valid_i & may_issue & ~is_local;

  assign lsu_gnt_o = is_local ? (local_req_valid_o & local_gnt_i)
                              : (ext_req_valid_o & ext_gnt_i);

  // responses come back in order from a single target at a time
  assign lsu_rvalid_o = local_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (resp_src_q == RESP_EXT) ? ext_rdata_i : local_rdata_i;

  always_comb
  begin
    outst_d = outst_q;
    if (lsu_gnt_o && !lsu_rvalid_o)
      outst_d = outst_q + 1'b1;
    else if (!lsu_gnt_o && lsu_rvalid_o)
      outst_d = outst_q - 1'b1;
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      resp_src_q <= RESP_LOCAL;
      outst_q    <= '0;
    end
    else
    begin
      outst_q <= outst_d;
      if (lsu_gnt_o)
        resp_src_q <= req_src;
    end
  end

  // no response without a request in flight
  assert property (@(posedge clk) disable iff (!rst_n) lsu_rvalid_o |-> (outst_q != '0));

  // targets never mixed, so each response comes from the recorded source
  assert property (@(posedge clk) disable iff (!rst_n)
    local_rvalid_i |-> (resp_src_q == RESP_LOCAL));

  assert property (@(posedge clk) disable iff (!rst_n)
    ext_rvalid_i |-> (resp_src_q == RESP_EXT));

endmodule

`default_nettype wire

//--- verilog/sp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sp_ram import core_region_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       en_i,
  input  wire logic                       we_i,
  input  wire logic [RAM_WORD_ADDR_W-1:0] addr_i,
  input  wire logic        [RAM_BE_W-1:0] be_i,
  input  wire logic      [RAM_DATA_W-1:0] wdata_i,
  output logic           [RAM_DATA_W-1:0] rdata_o
);

  logic [RAM_DATA_W-1:0] mem [RAM_WORDS];

  // byte-enabled write
  always_ff @(posedge clk)
  begin
    if (en_i && we_i)
    begin
      for (int i = 0; i < RAM_BE_W; i++)
      begin
        if (be_i[i])
          mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
      end
    end
  end

  // registered read, old contents on a write
  always_ff @(posedge clk)
  begin
    if (en_i)
      rdata_o <= mem[addr_i];
  end

endmodule

`default_nettype wire
